// File: proc_settings.svh
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// bus geometry
`define PROC_DATA_W     32
`define PROC_ADDR_W     9

// buffer geometry, one 32-bit word per index
`define PROC_BUF_DEPTH  32
`define PROC_IDX_W      5
`define PROC_ADDR_LSB   2

// register map
`define PROC_REG_CTRL   9'h000
`define PROC_REG_STAT   9'h004

// returned for addresses that hit nothing
`define PROC_UNMAPPED   32'hDEADBEEF

`endif

// File: proc_pkg.sv
`include "proc_settings.svh"

package proc_pkg;

    typedef logic [`PROC_DATA_W-1:0] data_t;
    typedef logic [`PROC_ADDR_W-1:0] addr_t;
    typedef logic [`PROC_IDX_W-1:0]  idx_t;
    typedef logic [7:0]              len_t;
    typedef logic [1:0]              burst_t;

    localparam burst_t BURST_FIXED = 2'b00;
    localparam burst_t BURST_INCR  = 2'b01;

    typedef enum logic [1:0] {WR_ADDR, WR_DATA, WR_RESP} wr_state_t;
    typedef enum logic {RD_ADDR, RD_DATA} rd_state_t;
    typedef enum logic {CORE_IDLE, CORE_COPY} core_state_t;

    // one accepted write beat
    typedef struct packed {
        logic  valid;
        addr_t addr;
        data_t data;
    } wr_beat_t;

    // buffer read request, sel high picks the output buffer
    typedef struct packed {
        logic sel;
        idx_t idx;
    } buf_rd_t;

    // address of the following beat; anything but FIXED steps one word
    function automatic addr_t next_addr(addr_t addr, burst_t burst);
        addr_t nxt;
        case (burst)
            BURST_FIXED: nxt = addr;
            default:     nxt = addr + addr_t'(1 << `PROC_ADDR_LSB);
        endcase
        return nxt;
    endfunction

endpackage

// File: axi_write_engine.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module axi_write_engine (
    input  logic               S_AXI_ACLK,
    input  logic               S_AXI_ARESETN,
    input  logic               awid,
    input  proc_pkg::addr_t    awaddr,
    input  proc_pkg::len_t     awlen,
    input  proc_pkg::burst_t   awburst,
    input  logic               awvalid,
    output logic               awready,
    input  proc_pkg::data_t    wdata,
    input  logic               wlast,
    input  logic               wvalid,
    output logic               wready,
    output logic               bid,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready,
    output proc_pkg::wr_beat_t wr_beat
);

    proc_pkg::wr_state_t state;
    proc_pkg::addr_t     cur_addr;
    proc_pkg::burst_t    aw_burst;
    proc_pkg::len_t      aw_len;
    proc_pkg::len_t      beat_cnt;
    logic                beat_valid;
    proc_pkg::addr_t     beat_addr;
    proc_pkg::data_t     beat_data;
    logic                aw_hs;
    logic                w_hs;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    // no error path, always OKAY
    assign bresp = 2'b00;

    assign wr_beat = '{valid: beat_valid, addr: beat_addr, data: beat_data};

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state      <= proc_pkg::WR_ADDR;
            awready    <= 1'b0;
            wready     <= 1'b0;
            bvalid     <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= w_hs;
            case (state)
                proc_pkg::WR_ADDR: begin
                    awready <= 1'b1;
                    if (aw_hs) begin
                        awready <= 1'b0;
                        wready  <= 1'b1;
                        state   <= proc_pkg::WR_DATA;
                    end
                end
                proc_pkg::WR_DATA: begin
                    if (w_hs && wlast) begin
                        wready <= 1'b0;
                        bvalid <= 1'b1;
                        state  <= proc_pkg::WR_RESP;
                    end
                end
                proc_pkg::WR_RESP: begin
                    // a stalled B holds off the next AW
                    if (bready) begin
                        bvalid  <= 1'b0;
                        awready <= 1'b1;
                        state   <= proc_pkg::WR_ADDR;
                    end
                end
                default: state <= proc_pkg::WR_ADDR;
            endcase
        end
    end

    // burst context and beat payload
    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs) begin
            bid      <= awid;
            aw_burst <= awburst;
            aw_len   <= awlen;
            cur_addr <= awaddr;
            beat_cnt <= '0;
        end else if (w_hs) begin
            cur_addr <= proc_pkg::next_addr(cur_addr, aw_burst);
            beat_cnt <= beat_cnt + 1'b1;
        end
        if (w_hs) begin
            beat_addr <= cur_addr;
            beat_data <= wdata;
        end
    end

    a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bvalid && !bready |=> bvalid);

    // master must mark the beat that matches AWLEN
    a_wlast_on_len: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        w_hs |-> (wlast == (beat_cnt == aw_len)));

endmodule

// File: axi_read_engine.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module axi_read_engine (
    input  logic             S_AXI_ACLK,
    input  logic             S_AXI_ARESETN,
    input  logic             arid,
    input  proc_pkg::addr_t  araddr,
    input  proc_pkg::len_t   arlen,
    input  proc_pkg::burst_t arburst,
    input  logic             arvalid,
    output logic             arready,
    output logic             rid,
    output proc_pkg::data_t  rdata,
    output logic [1:0]       rresp,
    output logic             rlast,
    output logic             rvalid,
    input  logic             rready,
    output proc_pkg::addr_t  rd_addr,
    input  proc_pkg::data_t  rd_data
);

    proc_pkg::rd_state_t state;
    proc_pkg::addr_t     cur_addr;
    proc_pkg::addr_t     adv_addr;
    proc_pkg::burst_t    ar_burst;
    proc_pkg::len_t      ar_len;
    proc_pkg::len_t      beat_cnt;
    logic                ar_hs;
    logic                r_adv;

    assign ar_hs = arvalid && arready;
    // a beat that is taken and is not the last one
    assign r_adv = rvalid && rready && !rlast;

    assign adv_addr = proc_pkg::next_addr(cur_addr, ar_burst);

    // decode the address of the beat that is loaded next
    assign rd_addr = (state == proc_pkg::RD_ADDR) ? araddr : adv_addr;

    assign rresp = 2'b00;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state   <= proc_pkg::RD_ADDR;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
        end else begin
            case (state)
                proc_pkg::RD_ADDR: begin
                    arready <= 1'b1;
                    if (ar_hs) begin
                        arready <= 1'b0;
                        rvalid  <= 1'b1;
                        rlast   <= (arlen == '0);
                        state   <= proc_pkg::RD_DATA;
                    end
                end
                proc_pkg::RD_DATA: begin
                    if (rready) begin
                        if (rlast) begin
                            rvalid  <= 1'b0;
                            rlast   <= 1'b0;
                            arready <= 1'b1;
                            state   <= proc_pkg::RD_ADDR;
                        end else begin
                            rlast <= (beat_cnt + 1'b1 == ar_len);
                        end
                    end
                end
                default: state <= proc_pkg::RD_ADDR;
            endcase
        end
    end

    // burst context, beat count and read data
    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_hs) begin
            rid      <= arid;
            ar_burst <= arburst;
            ar_len   <= arlen;
            cur_addr <= araddr;
            beat_cnt <= '0;
        end else if (r_adv) begin
            cur_addr <= adv_addr;
            beat_cnt <= beat_cnt + 1'b1;
        end
        if (ar_hs || r_adv) begin
            rdata <= rd_data;
        end
    end

    a_rlast_valid: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        rlast |-> rvalid);

    a_r_stall_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast));

endmodule

// File: proc_regs.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module proc_regs (
    input  logic               S_AXI_ACLK,
    input  logic               S_AXI_ARESETN,
    input  proc_pkg::wr_beat_t wr_beat,
    input  proc_pkg::addr_t    rd_addr,
    output proc_pkg::data_t    rd_data,
    output logic               start,
    input  logic               done,
    input  proc_pkg::idx_t     in_rd,
    output proc_pkg::data_t    in_word,
    output proc_pkg::idx_t     out_idx,
    input  proc_pkg::data_t    out_word
);

    proc_pkg::data_t   in_buf [`PROC_BUF_DEPTH];
    logic              done_flag;
    logic              wr_ctrl;
    logic              wr_stat;
    logic              wr_in;
    logic              clear_done;
    proc_pkg::idx_t    wr_idx;
    proc_pkg::buf_rd_t rd_sel;

    // write decode
    assign wr_ctrl = wr_beat.valid && (wr_beat.addr == `PROC_REG_CTRL);
    assign wr_stat = wr_beat.valid && (wr_beat.addr == `PROC_REG_STAT);

    // top bit marks the data region and the next bit picks the output half
    assign wr_in = wr_beat.valid
                && wr_beat.addr[`PROC_ADDR_W-1]
                && !wr_beat.addr[`PROC_ADDR_W-2];
    assign wr_idx = wr_beat.addr[`PROC_ADDR_LSB +: `PROC_IDX_W];

    // a 0 written to either register clears done
    assign clear_done = (wr_ctrl || wr_stat) && !wr_beat.data[0];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            start     <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                start <= wr_beat.data[0];
            end
            // the core's pulse wins over a clear
            if (done) begin
                done_flag <= 1'b1;
            end else if (clear_done) begin
                done_flag <= 1'b0;
            end
        end
    end

    // input buffer only takes input-half writes
    always_ff @(posedge S_AXI_ACLK) begin
        if (wr_in) begin
            in_buf[wr_idx] <= wr_beat.data;
        end
    end

    // core side read port
    assign in_word = in_buf[in_rd];

    // read decode
    assign rd_sel = '{
        sel: rd_addr[`PROC_ADDR_W-2],
        idx: rd_addr[`PROC_ADDR_LSB +: `PROC_IDX_W]
    };
    assign out_idx = rd_sel.idx;

    always_comb begin
        if (rd_addr == `PROC_REG_CTRL) begin
            rd_data = proc_pkg::data_t'(start);
        end else if (rd_addr == `PROC_REG_STAT) begin
            rd_data = proc_pkg::data_t'(done_flag);
        end else if (rd_addr[`PROC_ADDR_W-1]) begin
            if (rd_sel.sel) begin
                rd_data = out_word;
            end else begin
                rd_data = in_buf[rd_sel.idx];
            end
        end else begin
            rd_data = `PROC_UNMAPPED;
        end
    end

endmodule

// File: copy_core.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module copy_core (
    input  logic            S_AXI_ACLK,
    input  logic            S_AXI_ARESETN,
    input  logic            start,
    output proc_pkg::idx_t  in_idx,
    input  proc_pkg::data_t in_word,
    input  proc_pkg::idx_t  out_idx,
    output proc_pkg::data_t out_word,
    output logic            done
);

    proc_pkg::core_state_t state;
    proc_pkg::idx_t        idx;
    logic                  start_d;
    logic                  last_word;
    proc_pkg::data_t       out_buf [`PROC_BUF_DEPTH];

    assign in_idx    = idx;
    assign out_word  = out_buf[out_idx];
    assign last_word = (idx == proc_pkg::idx_t'(`PROC_BUF_DEPTH - 1));

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state   <= proc_pkg::CORE_IDLE;
            idx     <= '0;
            start_d <= 1'b0;
            done    <= 1'b0;
        end else begin
            start_d <= start;
            done    <= 1'b0;
            case (state)
                proc_pkg::CORE_IDLE: begin
                    // only a fresh rising edge starts a pass
                    if (start && !start_d) begin
                        idx   <= '0;
                        state <= proc_pkg::CORE_COPY;
                    end
                end
                proc_pkg::CORE_COPY: begin
                    idx <= idx + 1'b1;
                    if (last_word) begin
                        done  <= 1'b1;
                        state <= proc_pkg::CORE_IDLE;
                    end
                end
                default: state <= proc_pkg::CORE_IDLE;
            endcase
        end
    end

    // one word per cycle
    always_ff @(posedge S_AXI_ACLK) begin
        if (state == proc_pkg::CORE_COPY) begin
            out_buf[idx] <= in_word;
        end
    end

    // idx is 0 in COPY only on its first cycle
    a_no_done_at_begin: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (state == proc_pkg::CORE_COPY) && (idx == '0) |-> !done);

endmodule

// File: proc_full_axi.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module proc_full_axi (
    input  logic             S_AXI_ACLK,
    input  logic             S_AXI_ARESETN,
    input  logic             S_AXI_AWID,
    input  proc_pkg::addr_t  S_AXI_AWADDR,
    input  proc_pkg::len_t   S_AXI_AWLEN,
    input  proc_pkg::burst_t S_AXI_AWBURST,
    input  logic             S_AXI_AWVALID,
    output logic             S_AXI_AWREADY,
    input  proc_pkg::data_t  S_AXI_WDATA,
    input  logic             S_AXI_WLAST,
    input  logic             S_AXI_WVALID,
    output logic             S_AXI_WREADY,
    output logic             S_AXI_BID,
    output logic [1:0]       S_AXI_BRESP,
    output logic             S_AXI_BVALID,
    input  logic             S_AXI_BREADY,
    input  logic             S_AXI_ARID,
    input  proc_pkg::addr_t  S_AXI_ARADDR,
    input  proc_pkg::len_t   S_AXI_ARLEN,
    input  proc_pkg::burst_t S_AXI_ARBURST,
    input  logic             S_AXI_ARVALID,
    output logic             S_AXI_ARREADY,
    output logic             S_AXI_RID,
    output proc_pkg::data_t  S_AXI_RDATA,
    output logic [1:0]       S_AXI_RRESP,
    output logic             S_AXI_RLAST,
    output logic             S_AXI_RVALID,
    input  logic             S_AXI_RREADY
);

    proc_pkg::wr_beat_t wr_beat;
    proc_pkg::addr_t    rd_addr;
    proc_pkg::data_t    rd_data;
    logic               start;
    logic               done;
    proc_pkg::idx_t     in_idx;
    proc_pkg::data_t    in_word;
    proc_pkg::idx_t     out_idx;
    proc_pkg::data_t    out_word;

    axi_write_engine u_wr (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .awid          (S_AXI_AWID),
        .awaddr        (S_AXI_AWADDR),
        .awlen         (S_AXI_AWLEN),
        .awburst       (S_AXI_AWBURST),
        .awvalid       (S_AXI_AWVALID),
        .awready       (S_AXI_AWREADY),
        .wdata         (S_AXI_WDATA),
        .wlast         (S_AXI_WLAST),
        .wvalid        (S_AXI_WVALID),
        .wready        (S_AXI_WREADY),
        .bid           (S_AXI_BID),
        .bresp         (S_AXI_BRESP),
        .bvalid        (S_AXI_BVALID),
        .bready        (S_AXI_BREADY),
        .wr_beat       (wr_beat)
    );

    axi_read_engine u_rd (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .arid          (S_AXI_ARID),
        .araddr        (S_AXI_ARADDR),
        .arlen         (S_AXI_ARLEN),
        .arburst       (S_AXI_ARBURST),
        .arvalid       (S_AXI_ARVALID),
        .arready       (S_AXI_ARREADY),
        .rid           (S_AXI_RID),
        .rdata         (S_AXI_RDATA),
        .rresp         (S_AXI_RRESP),
        .rlast         (S_AXI_RLAST),
        .rvalid        (S_AXI_RVALID),
        .rready        (S_AXI_RREADY),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    // register block next to the core it steers
    proc_regs u_regs (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_beat       (wr_beat),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .start         (start),
        .done          (done),
        .in_rd         (in_idx),
        .in_word       (in_word),
        .out_idx       (out_idx),
        .out_word      (out_word)
    );

    copy_core u_core (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .start         (start),
        .in_idx        (in_idx),
        .in_word       (in_word),
        .out_idx       (out_idx),
        .out_word      (out_word),
        .done          (done)
    );

endmodule

// File: tb_proc_full_axi.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module tb_proc_full_axi;

    // generous bound over the whole test sequence
    localparam int MAX_CYCLES = 20000;

    logic             S_AXI_ACLK;
    logic             S_AXI_ARESETN;
    logic             S_AXI_AWID;
    proc_pkg::addr_t  S_AXI_AWADDR;
    proc_pkg::len_t   S_AXI_AWLEN;
    proc_pkg::burst_t S_AXI_AWBURST;
    logic             S_AXI_AWVALID;
    logic             S_AXI_AWREADY;
    proc_pkg::data_t  S_AXI_WDATA;
    logic             S_AXI_WLAST;
    logic             S_AXI_WVALID;
    logic             S_AXI_WREADY;
    logic             S_AXI_BID;
    logic [1:0]       S_AXI_BRESP;
    logic             S_AXI_BVALID;
    logic             S_AXI_BREADY;
    logic             S_AXI_ARID;
    proc_pkg::addr_t  S_AXI_ARADDR;
    proc_pkg::len_t   S_AXI_ARLEN;
    proc_pkg::burst_t S_AXI_ARBURST;
    logic             S_AXI_ARVALID;
    logic             S_AXI_ARREADY;
    logic             S_AXI_RID;
    proc_pkg::data_t  S_AXI_RDATA;
    logic [1:0]       S_AXI_RRESP;
    logic             S_AXI_RLAST;
    logic             S_AXI_RVALID;
    logic             S_AXI_RREADY;

    proc_pkg::data_t wq[$];
    proc_pkg::data_t rq[$];
    proc_pkg::data_t in_model [`PROC_BUF_DEPTH];
    proc_pkg::len_t  r_len;
    proc_pkg::len_t  r_beat;
    logic            wr_id;
    logic            rd_id;
    string           test_name;
    int              errs;
    int              checks;
    int              tests_run;
    int              tests_failed;
    int              errs_at_start;
    int              cycles;

    proc_full_axi dut (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #5 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    always @(posedge S_AXI_ACLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles in test %s", cycles, test_name);
            $display("Simulation failed");
            $finish;
        end
    end

    // beat position of the current read burst
    always @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            r_len  <= '0;
            r_beat <= '0;
        end else if (S_AXI_ARVALID && S_AXI_ARREADY) begin
            r_len  <= S_AXI_ARLEN;
            r_beat <= '0;
        end else if (S_AXI_RVALID && S_AXI_RREADY) begin
            r_beat <= r_beat + 1'b1;
        end
    end

    a_aw_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_AWVALID && !S_AXI_AWREADY |=> S_AXI_AWVALID)
        else note_error("AWVALID dropped before its handshake");
    a_w_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_WVALID && !S_AXI_WREADY |=> S_AXI_WVALID)
        else note_error("WVALID dropped before its handshake");
    a_b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
        else note_error("BVALID dropped before its handshake");
    a_ar_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_ARVALID && !S_AXI_ARREADY |=> S_AXI_ARVALID)
        else note_error("ARVALID dropped before its handshake");
    a_r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID)
        else note_error("RVALID dropped before its handshake");
    a_rlast_pos: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID |-> (S_AXI_RLAST == (r_beat == r_len)))
        else report_mismatch("RLAST", proc_pkg::data_t'($sampled(r_beat == r_len)),
                             proc_pkg::data_t'($sampled(S_AXI_RLAST)));
    a_bresp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID |-> (S_AXI_BRESP == 2'b00))
        else report_mismatch("BRESP", 32'h0, proc_pkg::data_t'($sampled(S_AXI_BRESP)));
    a_rresp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID |-> (S_AXI_RRESP == 2'b00))
        else report_mismatch("RRESP", 32'h0, proc_pkg::data_t'($sampled(S_AXI_RRESP)));
    a_bid_match: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID |-> (S_AXI_BID == wr_id))
        else report_mismatch("BID", proc_pkg::data_t'($sampled(wr_id)),
                             proc_pkg::data_t'($sampled(S_AXI_BID)));
    a_rid_match: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID |-> (S_AXI_RID == rd_id))
        else report_mismatch("RID", proc_pkg::data_t'($sampled(rd_id)),
                             proc_pkg::data_t'($sampled(S_AXI_RID)));

    task automatic note_error(input string msg);
        $display("error in test %s: %s", test_name, msg);
        errs++;
    endtask

    task automatic report_mismatch(input string what, input proc_pkg::data_t exp,
                                   input proc_pkg::data_t act);
        $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, exp, act);
        errs++;
    endtask

    task automatic check_word(input string what, input proc_pkg::data_t exp,
                              input proc_pkg::data_t act);
        checks++;
        if (exp !== act) begin
            report_mismatch(what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errs_at_start = errs;
        tests_run++;
    endtask

    task automatic end_test();
        if (errs != errs_at_start) begin
            tests_failed++;
            $display("test %s: FAILED", test_name);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    // burst write of all words in wq starting at a falling edge
    task automatic axi_write(input proc_pkg::addr_t addr, input proc_pkg::burst_t burst);
        int n;
        n = wq.size();
        wr_id         = 1'($urandom_range(1));
        S_AXI_AWID    = wr_id;
        S_AXI_AWADDR  = addr;
        S_AXI_AWLEN   = proc_pkg::len_t'(n - 1);
        S_AXI_AWBURST = burst;
        S_AXI_AWVALID = 1'b1;
        while (!S_AXI_AWREADY) @(negedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        S_AXI_AWVALID = 1'b0;
        // BID must come from the latched AWID
        S_AXI_AWID    = ~wr_id;
        for (int i = 0; i < n; i++) begin
            S_AXI_WDATA  = wq[i];
            S_AXI_WLAST  = (i == n - 1);
            S_AXI_WVALID = 1'b1;
            while (!S_AXI_WREADY) @(negedge S_AXI_ACLK);
            @(negedge S_AXI_ACLK);
        end
        S_AXI_WVALID = 1'b0;
        S_AXI_WLAST  = 1'b0;
        // late BREADY now and then
        repeat ($urandom_range(2)) @(negedge S_AXI_ACLK);
        S_AXI_BREADY = 1'b1;
        while (!S_AXI_BVALID) @(negedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        S_AXI_BREADY = 1'b0;
    endtask

    // burst read into rq with random RREADY stalls
    task automatic axi_read(input proc_pkg::addr_t addr, input proc_pkg::len_t len,
                            input proc_pkg::burst_t burst);
        int got;
        got = 0;
        rq.delete();
        rd_id         = 1'($urandom_range(1));
        S_AXI_ARID    = rd_id;
        S_AXI_ARADDR  = addr;
        S_AXI_ARLEN   = len;
        S_AXI_ARBURST = burst;
        S_AXI_ARVALID = 1'b1;
        while (!S_AXI_ARREADY) @(negedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        S_AXI_ARVALID = 1'b0;
        // RID must come from the latched ARID
        S_AXI_ARID    = ~rd_id;
        while (got < int'(len) + 1) begin
            S_AXI_RREADY = ($urandom_range(3) != 0);
            if (S_AXI_RVALID && S_AXI_RREADY) begin
                rq.push_back(S_AXI_RDATA);
                got++;
            end
            @(negedge S_AXI_ACLK);
        end
        S_AXI_RREADY = 1'b0;
    endtask

    task automatic write_word(input proc_pkg::addr_t addr, input proc_pkg::data_t data);
        wq.delete();
        wq.push_back(data);
        axi_write(addr, proc_pkg::BURST_INCR);
    endtask

    task automatic read_word(input proc_pkg::addr_t addr, output proc_pkg::data_t data);
        axi_read(addr, 8'd0, proc_pkg::BURST_INCR);
        data = rq[0];
    endtask

    initial begin
        proc_pkg::data_t word;
        proc_pkg::data_t last;
        int              polls;
        {S_AXI_AWID, S_AXI_AWADDR, S_AXI_AWLEN, S_AXI_AWBURST, S_AXI_AWVALID} = '0;
        {S_AXI_WDATA, S_AXI_WLAST, S_AXI_WVALID, S_AXI_BREADY} = '0;
        {S_AXI_ARID, S_AXI_ARADDR, S_AXI_ARLEN, S_AXI_ARBURST, S_AXI_ARVALID} = '0;
        S_AXI_RREADY  = 1'b0;
        S_AXI_ARESETN = 1'b0;
        wr_id         = 1'b0;
        rd_id         = 1'b0;
        {errs, checks, tests_run, tests_failed, errs_at_start, cycles} = '0;
        test_name = "reset";
        void'($urandom(41));
        repeat (3) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        @(negedge S_AXI_ACLK);

        begin_test("reset_values");
        read_word(`PROC_REG_CTRL, word);
        check_word("CTRL", 32'h0, word);
        read_word(`PROC_REG_STAT, word);
        check_word("STAT", 32'h0, word);
        read_word(9'h040, word);
        check_word("unmapped 0x040", `PROC_UNMAPPED, word);
        end_test();

        begin_test("incr_burst");
        wq.delete();
        for (int i = 0; i < `PROC_BUF_DEPTH; i++) begin
            in_model[i] = $urandom;
            wq.push_back(in_model[i]);
        end
        axi_write(9'h100, proc_pkg::BURST_INCR);
        axi_read(9'h100, 8'd31, proc_pkg::BURST_INCR);
        for (int i = 0; i < `PROC_BUF_DEPTH; i++) begin
            check_word($sformatf("input word %0d", i), in_model[i], rq[i]);
        end
        end_test();

        begin_test("copy_run");
        write_word(`PROC_REG_CTRL, 32'h1);
        polls = 0;
        word  = '0;
        while (word !== 32'h1 && polls < 40) begin
            read_word(`PROC_REG_STAT, word);
            polls++;
        end
        if (word !== 32'h1) begin
            note_error("STAT done bit not set within 40 polls");
        end else begin
            axi_read(9'h180, 8'd31, proc_pkg::BURST_INCR);
            for (int i = 0; i < `PROC_BUF_DEPTH; i++) begin
                check_word($sformatf("output word %0d", i), in_model[i], rq[i]);
            end
        end
        end_test();

        begin_test("clear_and_output_write");
        write_word(`PROC_REG_CTRL, 32'h0);
        read_word(`PROC_REG_STAT, word);
        check_word("STAT after clear", 32'h0, word);
        write_word(9'h180, ~in_model[0]);
        read_word(9'h180, word);
        check_word("output word 0", in_model[0], word);
        end_test();

        begin_test("fixed_burst");
        wq.delete();
        for (int i = 0; i < 4; i++) begin
            wq.push_back($urandom);
        end
        last        = wq[3];
        in_model[1] = last;
        axi_write(9'h104, proc_pkg::BURST_FIXED);
        axi_read(9'h104, 8'd3, proc_pkg::BURST_FIXED);
        for (int i = 0; i < 4; i++) begin
            check_word($sformatf("fixed beat %0d", i), last, rq[i]);
        end
        end_test();

        repeat (4) @(negedge S_AXI_ACLK);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errs);
        if (errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: proc_full_axi.f
+incdir+.
proc_pkg.sv
axi_write_engine.sv
axi_read_engine.sv
proc_regs.sv
copy_core.sv
proc_full_axi.sv
tb_proc_full_axi.sv
